// File: mac_bus_pkg.sv
`default_nettype none

package mac_bus_pkg;

    //////////////////////////////
    // chip host port timing
    //////////////////////////////

    localparam int DATA_WIDTH      = 16;  // width of the chip data port.
    localparam int STROBE_CYCLES   = 2;   // cycles with cs_n and ior_n/iow_n low.
    localparam int RECOVERY_CYCLES = 4;   // released cycles after each strobe.
    localparam int IRQ_SYNC_STAGES = 2;   // flops in the interrupt synchronizer.

    // one counter covers both the strobe and the recovery phase
    localparam int MAX_PHASE_CYCLES =
        (RECOVERY_CYCLES > STROBE_CYCLES) ? RECOVERY_CYCLES : STROBE_CYCLES;
    localparam int CNT_WIDTH = $clog2(MAX_PHASE_CYCLES + 1);

    //////////////////////////////
    // request and response words
    //////////////////////////////

    // processor side request, one raw chip access.
    typedef struct packed {
        logic                  write;  // 1 write, 0 read.
        logic                  cmd;    // 0 index port, 1 data port.
        logic [DATA_WIDTH-1:0] wdata;  // ignored on reads.
    } mac_req_t;

    // one response per request, in request order.
    typedef struct packed {
        logic                  write;  // echo of the request type.
        logic [DATA_WIDTH-1:0] rdata;  // zero for writes.
    } mac_rsp_t;

endpackage

`default_nettype wire

// File: pipe_reg.sv
`default_nettype none

// registered valid/ready stage with one skid slot
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          in_ready,
    output logic          out_valid,
    output payload_t      out_data,
    input  wire logic     out_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     skid_valid_next;
    logic     out_valid_next;
    logic     in_fire;
    logic     out_free;   // output register may be loaded this cycle.
    logic     load_out;
    logic     load_skid;

    assign in_fire  = in_valid && in_ready;
    assign out_free = out_ready || !out_valid;

    // the skid slot is drained first, so it never competes with in_data.
    assign load_out  = out_free && (skid_valid || in_fire);
    assign load_skid = in_fire && !out_free;

    always_comb begin
        skid_valid_next = skid_valid;
        out_valid_next  = out_valid;
        if (out_free) begin
            out_valid_next  = skid_valid || in_fire;
            skid_valid_next = 1'b0;
        end else if (in_fire) begin
            skid_valid_next = 1'b1;  // output stalled, park the new item.
        end
    end

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            skid_valid <= skid_valid_next;
            in_ready   <= !skid_valid_next;  // full once both slots hold data.
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (load_skid) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: mac_bus_access.sv
`default_nettype none

// one chip host port access at a time
module mac_bus_access
    import mac_bus_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  req_valid,
    output logic                       req_ready,
    input  wire mac_req_t              req,

    output logic                       rsp_valid,
    input  wire logic                  rsp_ready,
    output mac_rsp_t                   rsp,

    output logic                       cs_n,
    output logic                       ior_n,
    output logic                       iow_n,
    output logic                       cmd,
    output logic [DATA_WIDTH-1:0]      sd_out,
    output logic                       sd_oe,
    input  wire logic [DATA_WIDTH-1:0] sd_in,
    input  wire logic                  intr,
    output logic                       irq
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_RECOVERY,
        ST_RESPOND
    } state_t;

    state_t                     state;
    logic   [CNT_WIDTH-1:0]     cnt;
    logic                       accept;
    logic                       strobe_end;
    logic   [IRQ_SYNC_STAGES-1:0] irq_sync;

    assign req_ready  = (state == ST_IDLE);
    assign rsp_valid  = (state == ST_RESPOND);
    assign accept     = req_ready && req_valid;
    assign strobe_end = (state == ST_STROBE) && (cnt == '0);

    //////////////////////////////
    // access sequencer
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
            cs_n  <= 1'b1;
            ior_n <= 1'b1;
            iow_n <= 1'b1;
            sd_oe <= 1'b0;
        end else begin
            unique case (state)

                ST_IDLE: begin
                    if (req_valid) begin
                        cs_n  <= 1'b0;
                        ior_n <= req.write;
                        iow_n <= !req.write;
                        sd_oe <= req.write;  // drive the bus for writes only.
                        cnt   <= CNT_WIDTH'(STROBE_CYCLES - 1);
                        state <= ST_STROBE;
                    end
                end

                ST_STROBE: begin
                    if (cnt == '0) begin
                        cs_n  <= 1'b1;
                        ior_n <= 1'b1;
                        iow_n <= 1'b1;
                        sd_oe <= 1'b0;
                        cnt   <= CNT_WIDTH'(RECOVERY_CYCLES - 1);
                        state <= ST_RECOVERY;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                ST_RECOVERY: begin
                    // all strobes stay released here.
                    if (cnt == '0) begin
                        state <= ST_RESPOND;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end

                ST_RESPOND: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end

            endcase
        end
    end

    //////////////////////////////
    // address, data and response
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd        <= req.cmd;
            sd_out     <= req.wdata;
            rsp.write  <= req.write;
            rsp.rdata  <= '0;
        end
        // chip data is valid on the last strobe edge.
        if (strobe_end && !rsp.write) begin
            rsp.rdata <= sd_in;
        end
    end

    //////////////////////////////
    // interrupt synchronizer
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_sync <= '0;
        end else begin
            irq_sync <= {irq_sync[IRQ_SYNC_STAGES-2:0], intr};
        end
    end

    assign irq = irq_sync[IRQ_SYNC_STAGES-1];

endmodule

`default_nettype wire

// File: mac_bus_bridge.sv
`default_nettype none

// request stage, chip sequencer and response stage in a row
module mac_bus_bridge
    import mac_bus_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  req_valid,
    output logic                       req_ready,
    input  wire mac_req_t              req,

    output logic                       rsp_valid,
    input  wire logic                  rsp_ready,
    output mac_rsp_t                   rsp,

    output logic                       chip_rst_n,
    output logic                       chip_cs_n,
    output logic                       chip_ior_n,
    output logic                       chip_iow_n,
    output logic                       chip_cmd,
    output logic [DATA_WIDTH-1:0]      chip_sd_out,
    output logic                       chip_sd_oe,
    input  wire logic [DATA_WIDTH-1:0] chip_sd_in,
    input  wire logic                  chip_intr,
    output logic                       irq
);

    logic     acc_req_valid;
    logic     acc_req_ready;
    mac_req_t acc_req;
    logic     acc_rsp_valid;
    logic     acc_rsp_ready;
    mac_rsp_t acc_rsp;

    assign chip_rst_n = !rst;  // chip held in reset with the bridge.

    pipe_reg #(.payload_t(mac_req_t)) req_stage_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (req_valid),
        .in_data   (req),
        .in_ready  (req_ready),
        .out_valid (acc_req_valid),
        .out_data  (acc_req),
        .out_ready (acc_req_ready)
    );

    mac_bus_access access_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (acc_req_valid),
        .req_ready (acc_req_ready),
        .req       (acc_req),
        .rsp_valid (acc_rsp_valid),
        .rsp_ready (acc_rsp_ready),
        .rsp       (acc_rsp),
        .cs_n      (chip_cs_n),
        .ior_n     (chip_ior_n),
        .iow_n     (chip_iow_n),
        .cmd       (chip_cmd),
        .sd_out    (chip_sd_out),
        .sd_oe     (chip_sd_oe),
        .sd_in     (chip_sd_in),
        .intr      (chip_intr),
        .irq       (irq)
    );

    pipe_reg #(.payload_t(mac_rsp_t)) rsp_stage_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (acc_rsp_valid),
        .in_data   (acc_rsp),
        .in_ready  (acc_rsp_ready),
        .out_valid (rsp_valid),
        .out_data  (rsp),
        .out_ready (rsp_ready)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

// free running clock and a power-on reset
module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = !clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // release away from the active edge.
    end

endmodule

`default_nettype wire

// File: mac_chip_model.sv
`default_nettype none

// host port of a DM9000-like chip, 64 registers behind an index
module mac_chip_model
    import mac_bus_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  cs_n,
    input  wire logic                  ior_n,
    input  wire logic                  iow_n,
    input  wire logic                  cmd,
    input  wire logic [DATA_WIDTH-1:0] sd_out,
    input  wire logic                  sd_oe,
    input  wire logic                  raise_intr,
    output logic      [DATA_WIDTH-1:0] sd_in,
    output logic                       intr,
    output logic                       bus_fault
);

    logic [DATA_WIDTH-1:0] regs [64];
    logic [DATA_WIDTH-1:0] index;

    assign intr = raise_intr;

    // read data only while the read strobe is active.
    assign sd_in = (!cs_n && !ior_n) ? (cmd ? regs[index[5:0]] : index) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            index     <= '0;
            bus_fault <= 1'b0;
            for (int a = 0; a < 64; a++) begin
                regs[a] <= 16'ha5c3 ^ {2'b00, a[5:0], 2'b00, a[5:0]};
            end
        end else begin
            if (!cs_n && !iow_n) begin
                if (cmd) begin
                    regs[index[5:0]] <= sd_out;
                end else begin
                    index <= sd_out;
                end
            end
            // a write without driven data, or a read against the bus.
            if ((!cs_n && !iow_n && !sd_oe) || (!ior_n && sd_oe)) begin
                bus_fault <= 1'b1;
            end
            if (cs_n && (!ior_n || !iow_n)) begin
                bus_fault <= 1'b1;  // strobe without chip select.
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_mac_bus_bridge.sv
`default_nettype none

module tb_mac_bus_bridge
    import mac_bus_pkg::*;
;

    localparam int N_FIXED  = 8;
    localparam int N_RANDOM = 200;
    localparam int LIMIT    = (N_FIXED + N_RANDOM) * 12 + 200;

    logic clk, rst;
    logic req_valid, req_ready, rsp_valid, rsp_ready;
    mac_req_t req;
    mac_rsp_t rsp;
    logic chip_rst_n, chip_cs_n, chip_ior_n, chip_iow_n, chip_cmd, chip_sd_oe;
    logic [DATA_WIDTH-1:0] chip_sd_out, chip_sd_in;
    logic chip_intr, irq, raise_intr, bus_fault, backpressure;

    mac_rsp_t exp_q [$];
    mac_rsp_t exp_head;
    int exp_count, rsp_count, cyc, cs_low_cnt, idle_cnt, lat;
    logic [DATA_WIDTH-1:0] ref_regs [64];
    logic [DATA_WIDTH-1:0] ref_index;

    tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(10)) clock_i (.clk(clk), .rst(rst));

    mac_bus_bridge mac_bus_bridge_i (.*);

    mac_chip_model chip_i (
        .clk(clk), .rst_n(chip_rst_n), .cs_n(chip_cs_n), .ior_n(chip_ior_n),
        .iow_n(chip_iow_n), .cmd(chip_cmd), .sd_out(chip_sd_out), .sd_oe(chip_sd_oe),
        .raise_intr(raise_intr), .sd_in(chip_sd_in), .intr(chip_intr),
        .bus_fault(bus_fault)
    );

    task automatic fail_check(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    //////////////////////////////
    // scoreboard
    //////////////////////////////

    always @(posedge clk) begin
        cyc++;
        if (cyc > LIMIT) begin
            fail_check($sformatf("timeout, %0d responses still missing", exp_q.size()));
        end
        if (!rst && rsp_valid && rsp_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            rsp_count++;
        end
        if (!rst && req_valid && req_ready) begin
            if (req.write) begin
                if (req.cmd) ref_regs[ref_index[5:0]] = req.wdata;
                else ref_index = req.wdata;
                exp_q.push_back('{write: 1'b1, rdata: '0});
            end else begin
                exp_q.push_back('{write: 1'b0,
                                  rdata: req.cmd ? ref_regs[ref_index[5:0]] : ref_index});
            end
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
        cs_low_cnt = chip_cs_n ? 0 : cs_low_cnt + 1;
        if (chip_cs_n && chip_ior_n && chip_iow_n) idle_cnt = (idle_cnt < 255) ? idle_cnt + 1 : 255;
        else idle_cnt = 0;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && rsp_ready) |-> exp_count != 0)
        else fail_check("response arrived with no request outstanding");
    assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && rsp_ready && exp_count != 0) |-> rsp == exp_head)
        else fail_check($sformatf("MISMATCH rsp: got %h expected %h",
                                  $sampled(rsp), $sampled(exp_head)));
    assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else fail_check("response changed or vanished under back-pressure");
    assert property (@(posedge clk) disable iff (rst)
        $rose(chip_cs_n) |-> cs_low_cnt == STROBE_CYCLES)
        else fail_check($sformatf("MISMATCH chip_cs_n low cycles: got %h expected %h",
                                  $sampled(cs_low_cnt), STROBE_CYCLES));
    assert property (@(posedge clk) disable iff (rst)
        $fell(chip_cs_n) |-> idle_cnt >= RECOVERY_CYCLES)
        else fail_check("recovery time between chip accesses too short");
    assert property (@(posedge clk) disable iff (rst)
        chip_cs_n ? (chip_ior_n && chip_iow_n) : (chip_ior_n ^ chip_iow_n))
        else fail_check("chip strobes not exactly one of read or write under chip select");
    assert property (@(posedge clk) disable iff (rst)
        (!chip_cs_n && !$past(chip_cs_n)) |->
            ($stable(chip_cmd) && (chip_iow_n || $stable(chip_sd_out))))
        else fail_check("chip command or write data changed during a strobe");
    assert property (@(posedge clk) disable iff (rst)
        (!chip_iow_n |-> chip_sd_oe) and (!chip_ior_n |-> !chip_sd_oe))
        else fail_check("data output enable wrong during a strobe");
    assert property (@(posedge clk)
        rst |-> (chip_cs_n && chip_ior_n && chip_iow_n && !chip_sd_oe &&
                 !rsp_valid && !irq && !chip_rst_n))
        else fail_check("outputs not idle during reset");
    assert property (@(posedge clk)
        $fell(rst) |-> (chip_cs_n && !chip_sd_oe && !rsp_valid && !req_ready && !irq))
        else fail_check("outputs not idle right after reset");
    assert property (@(posedge clk) disable iff (rst)
        irq == $past(chip_intr, IRQ_SYNC_STAGES))
        else fail_check($sformatf("MISMATCH irq: got %h expected %h",
                                  $sampled(irq), $past(chip_intr, IRQ_SYNC_STAGES)));
    assert property (@(posedge clk) disable iff (rst) !bus_fault)
        else fail_check("chip model saw an illegal strobe combination");

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic send_req(input logic write, input logic cmd, input logic [15:0] wdata);
        req_valid = 1'b1;
        req       = '{write: write, cmd: cmd, wdata: wdata};
        while (!req_ready) @(negedge clk);
        @(negedge clk);  // taken on the edge in between.
        req_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        rsp_ready = backpressure ? ($urandom % 3 != 0) : 1'b1;
    end

    initial begin
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        raise_intr = 1'b0;
        backpressure = 1'b0;
        cyc = 0;
        cs_low_cnt = 0;
        idle_cnt = 255;
        rsp_count = 0;
        ref_index = '0;
        for (int a = 0; a < 64; a++) begin
            ref_regs[a] = 16'ha5c3 ^ {2'b00, a[5:0], 2'b00, a[5:0]};
        end
        void'($urandom(32'hc2001ba9));
        @(negedge clk);
        while (rst) @(negedge clk);

        // unloaded latency of one index read
        req_valid = 1'b1;
        req = '{write: 1'b0, cmd: 1'b0, wdata: '0};
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        lat = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        assert (lat == 8)
            else fail_check($sformatf("MISMATCH latency: got %h expected %h", lat, 8));

        send_req(1'b1, 1'b0, 16'h0005);
        send_req(1'b1, 1'b1, 16'h1234);
        send_req(1'b0, 1'b1, 16'h0000);
        send_req(1'b1, 1'b0, 16'h0009);
        send_req(1'b0, 1'b0, 16'h0000);
        send_req(1'b0, 1'b1, 16'h0000);
        send_req(1'b1, 1'b1, 16'hbeef);

        raise_intr = 1'b1;
        repeat (6) @(negedge clk);
        raise_intr = 1'b0;

        for (int i = 0; i < N_RANDOM; i++) begin
            if (i == N_RANDOM / 2) backpressure = 1'b1;
            case ($urandom % 4)
                0: send_req(1'b1, 1'b0, 16'($urandom % 64));
                1: send_req(1'b1, 1'b1, 16'($urandom));
                2: send_req(1'b0, 1'b1, 16'h0000);
                default: send_req(1'b0, 1'b0, 16'h0000);
            endcase
        end
        backpressure = 1'b0;
        while (rsp_count < N_FIXED + N_RANDOM) @(negedge clk);
        repeat (4) @(negedge clk);  // a late extra response still trips the checks.

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
mac_bus_pkg.sv
pipe_reg.sv
mac_bus_access.sv
mac_bus_bridge.sv
tb_clock_gen.sv
mac_chip_model.sv
tb_mac_bus_bridge.sv
